//--- design/decode_pkg.sv
package decode_pkg;

    // ########################################################################
    // Field widths
    // ########################################################################

    localparam int WORD_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 6;
    localparam int OPCODE_W   = 7;
    localparam int FUNC3_W    = 3;
    localparam int FUNC7_W    = 7;

    // Raw immediate widths before sign extension
    localparam int IMM_I_W = 12;
    localparam int IMM_B_W = 13;
    localparam int IMM_J_W = 21;

    // Entries 0 to 31 are the integer bank, 32 to 63 the float bank
    localparam int REG_COUNT = 64;

    // ########################################################################
    // Types
    // ########################################################################

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FUNC3_W-1:0]    func3_t;
    typedef logic [FUNC7_W-1:0]    func7_t;

    typedef enum logic [OPCODE_W-1:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_MEML   = 7'b0000011,
        OP_MEMS   = 7'b0100011,
        OP_FMEML  = 7'b0000111,
        OP_FMEMS  = 7'b0100111,
        OP_FPU    = 7'b1010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        // Memory-mapped I/O opcodes in the custom space
        OP_INPUT  = 7'b0001011,
        OP_OUTPUT = 7'b0101011
    } opcode_t;

endpackage

//--- design/decode_if.sv
`timescale 1ns/10ps

interface decode_if;
    import decode_pkg::*;

    opcode_t   opcode;
    func3_t    func3;
    func7_t    func7;
    reg_addr_t a_rd;

    logic alu;
    logic alu_imm_flag;
    logic alu_extention_flag;
    logic fpu;
    logic mem;
    logic jump;
    logic branch;
    logic subst;
    logic io;

    // Immediates, already sign extended to a full word
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t imm_u;

    modport dec (output opcode, func3, func7, a_rd,
                 output alu, alu_imm_flag, alu_extention_flag, fpu, mem,
                 output jump, branch, subst, io,
                 output imm_i, imm_s, imm_b, imm_j, imm_u);

    modport sel (input opcode, func3, func7, a_rd,
                 input alu, alu_imm_flag, alu_extention_flag, fpu, mem,
                 input jump, branch, subst, io,
                 input imm_i, imm_s, imm_b, imm_j, imm_u);

endinterface

//--- design/regread_if.sv
`timescale 1ns/10ps

interface regread_if;
    import decode_pkg::*;

    reg_addr_t a_rs1;
    reg_addr_t a_rs2;
    word_t     d_rs1;
    word_t     d_rs2;

    modport req (output a_rs1, a_rs2);

    modport rf (input a_rs1, a_rs2, output d_rs1, d_rs2);

    // Consumer side of the read data
    modport sel (input d_rs1, d_rs2);

endinterface

//--- design/inst_field_decode.sv
`timescale 1ns/10ps

module inst_field_decode (
    input  decode_pkg::inst_t inst,
    decode_if.dec             dec,
    regread_if.req            rd_req
);
    import decode_pkg::*;

    opcode_t            op;
    logic               float_class;
    logic [IMM_I_W-1:0] raw_i;
    logic [IMM_I_W-1:0] raw_s;
    logic [IMM_B_W-1:0] raw_b;
    logic [IMM_J_W-1:0] raw_j;

    // ########################################################################
    // Fields and class flags
    // ########################################################################

    // The cast keeps undefined encodings, which then match no class below
    assign op = opcode_t'(inst[6:0]);

    assign dec.opcode = op;
    assign dec.func3  = inst[14:12];
    assign dec.func7  = inst[31:25];

    assign dec.alu    = (op == OP_ALU) || (op == OP_ALUI);
    assign dec.fpu    = (op == OP_FPU);
    assign dec.mem    = (op == OP_MEML) || (op == OP_MEMS)
                     || (op == OP_FMEML) || (op == OP_FMEMS);
    assign dec.jump   = (op == OP_JAL) || (op == OP_JALR);
    assign dec.branch = (op == OP_BRANCH);
    assign dec.subst  = (op == OP_LUI) || (op == OP_AUIPC);
    assign dec.io     = (op == OP_INPUT) || (op == OP_OUTPUT);

    assign dec.alu_imm_flag       = (op == OP_ALUI);
    assign dec.alu_extention_flag = (op == OP_ALU) && inst[25];

    // ########################################################################
    // Register addresses
    // ########################################################################

    assign float_class = (op == OP_FPU) || (op == OP_FMEML) || (op == OP_FMEMS);

    // Float loads and stores still take their base from the integer bank
    assign dec.a_rd     = {float_class, inst[11:7]};
    assign rd_req.a_rs1 = {(op == OP_FPU), inst[19:15]};
    assign rd_req.a_rs2 = {float_class, inst[24:20]};

    // ########################################################################
    // Immediates
    // ########################################################################

    assign raw_i = inst[31:20];
    assign raw_s = {inst[31:25], inst[11:7]};
    assign raw_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign raw_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign dec.imm_i = {{(WORD_W-IMM_I_W){raw_i[IMM_I_W-1]}}, raw_i};
    assign dec.imm_s = {{(WORD_W-IMM_I_W){raw_s[IMM_I_W-1]}}, raw_s};
    assign dec.imm_b = {{(WORD_W-IMM_B_W){raw_b[IMM_B_W-1]}}, raw_b};
    assign dec.imm_j = {{(WORD_W-IMM_J_W){raw_j[IMM_J_W-1]}}, raw_j};

    // Upper immediate fills the low 12 bits with zeros
    assign dec.imm_u = {inst[31:12], 12'b0};

endmodule

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wb_en,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    regread_if.rf                 rd
);
    import decode_pkg::*;

    word_t regs [REG_COUNT];
    logic  wb_live;

    // Integer register 0 is never written
    assign wb_live = wb_en && (wb_addr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // ########################################################################
    // Read ports with writeback bypass
    // ########################################################################

    always_comb begin
        if (rd.a_rs1 == '0) begin
            rd.d_rs1 = '0;
        end else if (wb_live && (wb_addr == rd.a_rs1)) begin
            rd.d_rs1 = wb_data;
        end else begin
            rd.d_rs1 = regs[rd.a_rs1];
        end
    end

    always_comb begin
        if (rd.a_rs2 == '0) begin
            rd.d_rs2 = '0;
        end else if (wb_live && (wb_addr == rd.a_rs2)) begin
            rd.d_rs2 = wb_data;
        end else begin
            rd.d_rs2 = regs[rd.a_rs2];
        end
    end

endmodule

//--- design/operand_select.sv
`timescale 1ns/10ps

module operand_select (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  decode_pkg::word_t     pc,
    decode_if.sel                 dec,
    regread_if.sel                rd,
    output logic                  out_valid,
    output logic                  alu,
    output logic                  alu_imm_flag,
    output logic                  alu_extention_flag,
    output logic                  fpu,
    output logic                  mem,
    output logic                  jump,
    output logic                  branch,
    output logic                  subst,
    output logic                  io,
    output decode_pkg::word_t     d_rs1,
    output decode_pkg::word_t     d_rs2,
    output decode_pkg::word_t     d_rs3,
    output decode_pkg::reg_addr_t a_rd,
    output decode_pkg::opcode_t   opcode,
    output decode_pkg::func3_t    func3,
    output decode_pkg::func7_t    func7
);
    import decode_pkg::*;

    word_t jal_target;
    word_t rs1_next;
    word_t rs2_next;
    word_t rs3_next;

    // Shared by d_rs1 and d_rs3 for OP_JAL
    assign jal_target = dec.imm_j + pc;

    always_comb begin
        case (dec.opcode)
            OP_MEML, OP_FMEML, OP_JALR: rs1_next = rd.d_rs1 + dec.imm_i;
            OP_MEMS, OP_FMEMS:          rs1_next = rd.d_rs1 + dec.imm_s;
            OP_JAL:                     rs1_next = jal_target;
            default:                    rs1_next = rd.d_rs1;
        endcase
    end

    assign rs2_next = (dec.opcode == OP_ALUI) ? dec.imm_i : rd.d_rs2;

    always_comb begin
        case (dec.opcode)
            OP_MEMS, OP_FMEMS: rs3_next = dec.imm_s;
            OP_BRANCH:         rs3_next = dec.imm_b + pc;
            OP_JAL:            rs3_next = jal_target;
            OP_LUI:            rs3_next = dec.imm_u;
            OP_AUIPC:          rs3_next = dec.imm_u + pc;
            default:           rs3_next = dec.imm_i;
        endcase
    end

    // ########################################################################
    // Output register
    // ########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid          <= 1'b0;
            alu                <= 1'b0;
            alu_imm_flag       <= 1'b0;
            alu_extention_flag <= 1'b0;
            fpu                <= 1'b0;
            mem                <= 1'b0;
            jump               <= 1'b0;
            branch             <= 1'b0;
            subst              <= 1'b0;
            io                 <= 1'b0;
            d_rs1              <= '0;
            d_rs2              <= '0;
            d_rs3              <= '0;
            a_rd               <= '0;
            opcode             <= opcode_t'('0);
            func3              <= '0;
            func7              <= '0;
        end else begin
            out_valid <= inst_valid;
            if (inst_valid) begin
                alu                <= dec.alu;
                alu_imm_flag       <= dec.alu_imm_flag;
                alu_extention_flag <= dec.alu_extention_flag;
                fpu                <= dec.fpu;
                mem                <= dec.mem;
                jump               <= dec.jump;
                branch             <= dec.branch;
                subst              <= dec.subst;
                io                 <= dec.io;
                d_rs1              <= rs1_next;
                d_rs2              <= rs2_next;
                d_rs3              <= rs3_next;
                a_rd               <= dec.a_rd;
                opcode             <= dec.opcode;
                func3              <= dec.func3;
                func7              <= dec.func7;
            end
        end
    end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  decode_pkg::inst_t     inst,
    input  decode_pkg::word_t     pc,
    input  logic                  wb_en,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    output logic                  out_valid,
    output logic                  alu,
    output logic                  alu_imm_flag,
    output logic                  alu_extention_flag,
    output logic                  fpu,
    output logic                  mem,
    output logic                  jump,
    output logic                  branch,
    output logic                  subst,
    output logic                  io,
    output decode_pkg::word_t     d_rs1,
    output decode_pkg::word_t     d_rs2,
    output decode_pkg::word_t     d_rs3,
    output decode_pkg::reg_addr_t a_rd,
    output decode_pkg::opcode_t   opcode,
    output decode_pkg::func3_t    func3,
    output decode_pkg::func7_t    func7
);

    decode_if  dec_bus ();
    regread_if rd_bus ();

    inst_field_decode u_field_decode (
        .inst   (inst),
        .dec    (dec_bus.dec),
        .rd_req (rd_bus.req)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rd      (rd_bus.rf)
    );

    // Registered result appears one cycle after inst_valid
    operand_select u_operand_select (
        .clk                (clk),
        .arst_n             (arst_n),
        .inst_valid         (inst_valid),
        .pc                 (pc),
        .dec                (dec_bus.sel),
        .rd                 (rd_bus.sel),
        .out_valid          (out_valid),
        .alu                (alu),
        .alu_imm_flag       (alu_imm_flag),
        .alu_extention_flag (alu_extention_flag),
        .fpu                (fpu),
        .mem                (mem),
        .jump               (jump),
        .branch             (branch),
        .subst              (subst),
        .io                 (io),
        .d_rs1              (d_rs1),
        .d_rs2              (d_rs2),
        .d_rs3              (d_rs3),
        .a_rd               (a_rd),
        .opcode             (opcode),
        .func3              (func3),
        .func7              (func7)
    );

endmodule

//--- verif/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Flags in the order alu, alu_imm, alu_ext, fpu, mem, jump, branch, subst, io
typedef struct packed {
    inst_t      inst;
    logic [8:0] flags;
    reg_addr_t  a_rd;
    word_t      d_rs1;
    word_t      d_rs2;
    word_t      d_rs3;
} expect_t;

// Mirror of the register file contents
word_t model_regs [REG_COUNT];

function automatic void model_write(input reg_addr_t addr, input word_t data);
    if (addr != '0) begin
        model_regs[addr] = data;
    end
endfunction

function automatic expect_t predict(input inst_t i, input word_t pc_v);
    expect_t e;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;
    logic    is_float;
    imm_i    = {{20{i[31]}}, i[31:20]};
    imm_s    = {{20{i[31]}}, i[31:25], i[11:7]};
    imm_b    = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    imm_j    = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    imm_u    = {i[31:12], 12'b0};
    is_float = (i[6:0] == OP_FPU) || (i[6:0] == OP_FMEML) || (i[6:0] == OP_FMEMS);
    e.inst   = i;
    e.flags  = '0;
    e.a_rd   = {is_float, i[11:7]};
    // Only FPU operations take rs1 from the float bank
    e.d_rs1  = model_regs[{i[6:0] == OP_FPU, i[19:15]}];
    e.d_rs2  = model_regs[{is_float, i[24:20]}];
    e.d_rs3  = imm_i;
    case (i[6:0])
        OP_ALU:              e.flags = {2'b10, i[25], 6'b0};
        OP_FPU:              e.flags = 9'b000_100_000;
        OP_INPUT, OP_OUTPUT: e.flags = 9'b000_000_001;
        OP_ALUI: begin
            e.flags = 9'b110_000_000;
            e.d_rs2 = imm_i;
        end
        OP_MEML, OP_FMEML, OP_JALR: begin
            e.flags = (i[6:0] == OP_JALR) ? 9'b000_001_000 : 9'b000_010_000;
            e.d_rs1 = e.d_rs1 + imm_i;
        end
        OP_MEMS, OP_FMEMS: begin
            e.flags = 9'b000_010_000;
            e.d_rs1 = e.d_rs1 + imm_s;
            e.d_rs3 = imm_s;
        end
        OP_BRANCH: begin
            e.flags = 9'b000_000_100;
            e.d_rs3 = imm_b + pc_v;
        end
        OP_JAL: begin
            e.flags = 9'b000_001_000;
            e.d_rs1 = imm_j + pc_v;
            e.d_rs3 = imm_j + pc_v;
        end
        OP_LUI, OP_AUIPC: begin
            e.flags = 9'b000_000_010;
            e.d_rs3 = (i[6:0] == OP_AUIPC) ? imm_u + pc_v : imm_u;
        end
        default: ;
    endcase
    return e;
endfunction

`endif

//--- verif/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;
    import decode_pkg::*;

    `include "decode_ref_model.svh"

    // About four times the cycles used by all tests together
    localparam int MAX_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        arst_n, inst_valid, wb_en, out_valid;
    inst_t       inst;
    word_t       pc, wb_data, d_rs1, d_rs2, d_rs3;
    reg_addr_t   wb_addr, a_rd;
    logic        alu, alu_imm_flag, alu_extention_flag, fpu, mem, jump, branch, subst, io;
    opcode_t     opcode;
    func3_t      func3;
    func7_t      func7;
    logic [31:0] lfsr = 32'd56;
    int          cycles = 0;

    decode_stage uut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycles);
            $display("TEST FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    // ########################################################################
    // Random stimulus from a 32-bit Fibonacci LFSR with taps 32 22 2 1
    // ########################################################################

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t lfsr_word(input int nbits);
        word_t w;
        w = '0;
        for (int k = 0; k < nbits; k++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic inst_t random_inst(input logic [6:0] op);
        return (lfsr_word(25) << 7) | inst_t'(op);
    endfunction

    // ########################################################################
    // Drivers and result check
    // ########################################################################

    task automatic check_result(input expect_t e);
        string      what;
        logic [8:0] flags;
        flags = {alu, alu_imm_flag, alu_extention_flag, fpu, mem, jump, branch, subst, io};
        what  = "";
        if (out_valid !== 1'b1)
            what = "out_valid low one cycle after issue";
        else if (flags !== e.flags)
            what = $sformatf("flags %b, expected %b", flags, e.flags);
        else if (a_rd !== e.a_rd)
            what = $sformatf("a_rd %h, expected %h", a_rd, e.a_rd);
        else if (d_rs1 !== e.d_rs1)
            what = $sformatf("d_rs1 %h, expected %h", d_rs1, e.d_rs1);
        else if (d_rs2 !== e.d_rs2)
            what = $sformatf("d_rs2 %h, expected %h", d_rs2, e.d_rs2);
        else if (d_rs3 !== e.d_rs3)
            what = $sformatf("d_rs3 %h, expected %h", d_rs3, e.d_rs3);
        else if ({func7, func3, opcode} !== {e.inst[31:25], e.inst[14:12], e.inst[6:0]})
            what = "opcode, func3 or func7 differs from the instruction";
        assert (what == "") else begin
            $display("Fail at %0d ns: %s for inst %h", $time, what, e.inst);
            $display("TEST FAIL");
            $fatal(1, "Decode result mismatch");
        end
    endtask

    // Drive one instruction and check its result one cycle later
    task automatic issue(input inst_t i, input word_t p, input logic wb = 1'b0,
                         input reg_addr_t a = '0, input word_t d = '0);
        expect_t e;
        inst_valid = 1'b1;
        inst       = i;
        pc         = p;
        wb_en      = wb;
        wb_addr    = a;
        wb_data    = d;
        // A writeback in the same cycle is seen through the bypass
        if (wb) begin
            model_write(a, d);
        end
        e = predict(i, p);
        @(negedge clk);
        inst_valid = 1'b0;
        wb_en      = 1'b0;
        check_result(e);
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        wb_en   = 1'b1;
        wb_addr = a;
        wb_data = d;
        model_write(a, d);
        @(negedge clk);
        wb_en = 1'b0;
        // No instruction was issued in this cycle
        assert (out_valid === 1'b0) else begin
            $display("Fail at %0d ns: out_valid high without an instruction", $time);
            $display("TEST FAIL");
            $fatal(1, "Unexpected out_valid");
        end
    endtask

    task automatic issue_random(input logic [6:0] op, input int count);
        repeat (count) begin
            issue(random_inst(op), lfsr_word(32));
        end
    endtask

    // ########################################################################
    // Directed tests
    // ########################################################################

    task automatic alu_register_reads();
        assert ((out_valid === 1'b0)
                && ({alu, alu_imm_flag, alu_extention_flag, fpu, mem, jump, branch, subst,
                     io, a_rd, opcode, func3, func7, d_rs1, d_rs2, d_rs3} === '0)) else begin
            $display("Fail at %0d ns: outputs not cleared by reset", $time);
            $display("TEST FAIL");
            $fatal(1, "Reset state mismatch");
        end
        issue_random(OP_ALU, 4);
        // Entry 0 is written too and has to keep reading zero
        for (int a = 0; a < REG_COUNT; a++) begin
            write_reg(reg_addr_t'(a), lfsr_word(32));
        end
        repeat (16) begin
            write_reg(reg_addr_t'(lfsr_word(6)), lfsr_word(32));
        end
        issue({7'b0100001, 5'd7, 5'd0, 3'b000, 5'd9, OP_ALU}, '0);
        issue_random(OP_ALU, 40);
    endtask

    task automatic load_store_addresses();
        issue_random(OP_MEML, 25);
        issue_random(OP_MEMS, 25);
        issue_random(OP_FMEML, 25);
        issue_random(OP_FMEMS, 25);
    endtask

    task automatic control_flow_targets();
        issue_random(OP_BRANCH, 20);
        issue_random(OP_JAL, 20);
        issue_random(OP_JALR, 20);
        issue_random(OP_LUI, 20);
        issue_random(OP_AUIPC, 20);
    endtask

    task automatic fpu_io_and_undefined();
        issue_random(OP_FPU, 20);
        issue_random(OP_INPUT, 20);
        issue_random(OP_OUTPUT, 20);
        issue_random(7'b1111111, 20);
    endtask

    task automatic back_to_back_bypass();
        inst_t i;
        repeat (30) begin
            i = random_inst(OP_ALU);
            issue(i, lfsr_word(32), 1'b1, {1'b0, i[19:15]}, lfsr_word(32));
            i = random_inst(OP_FPU);
            issue(i, lfsr_word(32), 1'b1, {1'b1, i[24:20]}, lfsr_word(32));
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        wb_en      = 1'b0;
        wb_addr    = '0;
        wb_data    = '0;
        for (int k = 0; k < REG_COUNT; k++) begin
            model_regs[k] = '0;
        end
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        alu_register_reads();
        issue_random(OP_ALUI, 40);
        load_store_addresses();
        control_flow_targets();
        fpu_io_and_undefined();
        back_to_back_bypass();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
design/decode_pkg.sv
design/decode_if.sv
design/regread_if.sv
design/inst_field_decode.sv
design/reg_file.sv
design/operand_select.sv
design/decode_stage.sv
verif/decode_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps --top-module decode_stage_tb -f vlog.f

./obj_dir/Vdecode_stage_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
